/* golay24_settings.svh */
// golay24 reliability front end settings
// widths of the soft and code domains and length of the sorted list

`ifndef GOLAY24_SETTINGS_SVH
`define GOLAY24_SETTINGS_SVH

//------------------------------------------------------------
// soft domain
//------------------------------------------------------------
`define GOLAY24_LLR_W   8   // channel llr width
`define GOLAY24_MAG_W   7   // magnitude width, llr width minus sign

//------------------------------------------------------------
// code domain
//------------------------------------------------------------
`define GOLAY24_N       24  // codeword length
`define GOLAY24_POS_W   5   // enough for index 0..23
`define GOLAY24_LRP_NUM 4   // least reliable entries kept

`endif

/* golay24_soft_pkg.sv */
// golay24 soft value types
// signed channel llr and the unsigned reliability magnitude
// taken from it by stage 1 of the front end

`include "golay24_settings.svh"

package golay24_soft_pkg;

  //------------------------------------------------------------
  // channel side
  //------------------------------------------------------------
  typedef logic signed [`GOLAY24_LLR_W-1:0] llr_t;  // negative llr decodes as 1

  //------------------------------------------------------------
  // reliability side
  //------------------------------------------------------------
  typedef logic [`GOLAY24_MAG_W-1:0] mag_t;         // saturated abs of llr

endpackage

/* golay24_code_pkg.sv */
// golay24 codeword types
// bit index within a codeword and the 24 bit hard decision word
// assembled from the llr signs

`include "golay24_settings.svh"

package golay24_code_pkg;

  //------------------------------------------------------------
  // position inside the codeword
  //------------------------------------------------------------
  typedef logic [`GOLAY24_POS_W-1:0] pos_t;  // symbol index 0..23

  //------------------------------------------------------------
  // hard decision word
  //------------------------------------------------------------
  typedef logic [`GOLAY24_N-1:0] word_t;     // bit i from symbol i

endpackage

/* golay24_llr_mag.sv */
// golay24 llr magnitude extraction, stage 1
// registers the llr sign as hard bit, the saturated magnitude
// and the symbol position inside the codeword

`timescale 1ns/1ps

`include "golay24_settings.svh"

module golay24_llr_mag (
  input  logic                      iclk,
  input  logic                      rst_n,
  input  logic                      clkena,
  input  logic                      sop,     // symbol 0 of codeword
  input  logic                      val,
  input  golay24_soft_pkg::llr_t    llr,
  output logic                      load,    // first symbol to sort list
  output logic                      val_out,
  output logic                      hard,
  output golay24_soft_pkg::mag_t    mag,
  output golay24_code_pkg::pos_t    pos
);

  //------------------------------------------------------------
  // saturated absolute value
  //------------------------------------------------------------
  golay24_soft_pkg::llr_t  neg_llr;   // two's complement negation
  golay24_soft_pkg::mag_t  mag_c;
  logic                    llr_min;   // most negative code
  golay24_code_pkg::pos_t  cnt;       // index of next symbol

  assign neg_llr = -llr;
  assign llr_min = llr[`GOLAY24_LLR_W-1] && (llr[`GOLAY24_MAG_W-1:0] == '0);
  assign mag_c   = llr_min                ? '1 :                       // clip to max
                   llr[`GOLAY24_LLR_W-1]  ? neg_llr[`GOLAY24_MAG_W-1:0] :
                                            llr[`GOLAY24_MAG_W-1:0];

  //------------------------------------------------------------
  // control path
  //------------------------------------------------------------
  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      load    <= 1'b0;
      val_out <= 1'b0;
      cnt     <= '0;
    end else if (clkena) begin
      load    <= val & sop;
      val_out <= val;
      if (val) begin
        cnt <= sop ? golay24_code_pkg::pos_t'(1) : cnt + 1'b1;  // restart on sop
      end
    end
  end

  // payload, only looked at with val_out high
  always_ff @(posedge iclk) begin
    if (clkena && val) begin
      hard <= llr[`GOLAY24_LLR_W-1];           // sign bit is the hard decision
      mag  <= mag_c;
      pos  <= sop ? '0 : cnt;
    end
  end

endmodule

/* golay24_dec_sort_list_cell.sv */
// golay24 sort list cell
// one entry of the ascending insertion list. compares the new
// magnitude with the stored one and either shifts in the entry of
// the previous cell, takes the new symbol, or keeps its contents

`timescale 1ns/1ps

module golay24_dec_sort_list_cell #(
  parameter bit pINIT_NLOAD = 1'b0   // 1 -> set to max on load, 0 -> take symbol
) (
  input  logic                      iclk,
  input  logic                      rst_n,
  input  logic                      clkena,
  input  logic                      load,        // restart list
  input  logic                      val,
  input  golay24_soft_pkg::mag_t    dat,         // new magnitude
  input  golay24_code_pkg::pos_t    idx,         // new position
  input  logic                      carry_prev,  // previous cell shifts
  input  golay24_soft_pkg::mag_t    dat_prev,
  input  golay24_code_pkg::pos_t    idx_prev,
  output logic                      carry,       // new value below stored one
  output golay24_soft_pkg::mag_t    dat_out,
  output golay24_code_pkg::pos_t    idx_out
);

  //------------------------------------------------------------
  // stored entry
  //------------------------------------------------------------
  golay24_soft_pkg::mag_t  dat_r;
  golay24_code_pkg::pos_t  idx_r;

  // strict compare so equal magnitudes keep the earlier position first
  assign carry = (dat < dat_r);

  //------------------------------------------------------------
  // update
  //------------------------------------------------------------
  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      dat_r <= '1;                        // empty entry is max magnitude
      idx_r <= '0;
    end else if (clkena) begin
      if (load) begin
        if (pINIT_NLOAD) begin
          dat_r <= '1;                    // clear tail of list
          idx_r <= '0;
        end else begin
          dat_r <= dat;                   // head takes first symbol
          idx_r <= idx;
        end
      end else if (val) begin
        if (carry_prev) begin
          dat_r <= dat_prev;              // shift down from upper cell
          idx_r <= idx_prev;
        end else if (carry) begin
          dat_r <= dat;                   // insertion point
          idx_r <= idx;
        end
      end
    end
  end

  assign dat_out = dat_r;
  assign idx_out = idx_r;

endmodule

/* golay24_dec_sort_list.sv */
// golay24 sort list, stage 2
// chain of cells forming a sequential ascending sort of the
// symbol magnitudes. one cycle per decision, entry 0 holds the smallest

`timescale 1ns/1ps

`include "golay24_settings.svh"

module golay24_dec_sort_list #(
  parameter int pIDX_NUM = `GOLAY24_LRP_NUM   // list length
) (
  input  logic                      iclk,
  input  logic                      rst_n,
  input  logic                      clkena,
  input  logic                      load,
  input  logic                      val,
  input  golay24_soft_pkg::mag_t    dat,
  input  golay24_code_pkg::pos_t    idx,
  output golay24_soft_pkg::mag_t    odat [pIDX_NUM],
  output golay24_code_pkg::pos_t    oidx [pIDX_NUM]
);

  //------------------------------------------------------------
  // chain wiring
  //------------------------------------------------------------
  logic                    carry_prev [pIDX_NUM];
  golay24_soft_pkg::mag_t  dat_prev   [pIDX_NUM];
  golay24_code_pkg::pos_t  idx_prev   [pIDX_NUM];
  logic                    carry      [pIDX_NUM];

  for (genvar i = 0; i < pIDX_NUM; i++) begin : g_cell
    golay24_dec_sort_list_cell #(
      .pINIT_NLOAD (i != 0)                  // only head loads the symbol
    ) u_cell (
      .iclk       (iclk),
      .rst_n      (rst_n),
      .clkena     (clkena),
      .load       (load),
      .val        (val),
      .dat        (dat),
      .idx        (idx),
      .carry_prev (carry_prev[i]),
      .dat_prev   (dat_prev[i]),
      .idx_prev   (idx_prev[i]),
      .carry      (carry[i]),
      .dat_out    (odat[i]),
      .idx_out    (oidx[i])
    );

    if (i == 0) begin : g_head
      assign carry_prev[i] = 1'b0;          // nothing above the head
      assign dat_prev[i]   = '0;
      assign idx_prev[i]   = '0;
    end else begin : g_link
      assign carry_prev[i] = carry[i-1];
      assign dat_prev[i]   = odat[i-1];
      assign idx_prev[i]   = oidx[i-1];
    end
  end

endmodule

/* golay24_lrp_out.sv */
// golay24 result capture, stage 3
// assembles the hard decision word from the symbol signs and
// captures it with the finished sort list once per codeword

`timescale 1ns/1ps

`include "golay24_settings.svh"

module golay24_lrp_out (
  input  logic                      iclk,
  input  logic                      rst_n,
  input  logic                      clkena,
  input  logic                      val,
  input  logic                      hard,
  input  golay24_code_pkg::pos_t    pos,
  input  golay24_soft_pkg::mag_t    dat     [`GOLAY24_LRP_NUM],
  input  golay24_code_pkg::pos_t    idx     [`GOLAY24_LRP_NUM],
  output logic                      res_val,
  output golay24_code_pkg::word_t   res_word,
  output golay24_soft_pkg::mag_t    res_mag [`GOLAY24_LRP_NUM],
  output golay24_code_pkg::pos_t    res_pos [`GOLAY24_LRP_NUM]
);

  //------------------------------------------------------------
  // word assembly
  //------------------------------------------------------------
  golay24_code_pkg::word_t  asm_word;   // every bit rewritten per codeword
  logic                     last_d;     // list complete next cycle

  always_ff @(posedge iclk) begin
    if (clkena && val) begin
      asm_word[pos] <= hard;
    end
  end

  //------------------------------------------------------------
  // capture
  //------------------------------------------------------------
  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      last_d   <= 1'b0;
      res_val  <= 1'b0;
      res_word <= '0;
      res_mag  <= '{default: '0};
      res_pos  <= '{default: '0};
    end else if (clkena) begin
      last_d  <= val && (pos == golay24_code_pkg::pos_t'(`GOLAY24_N-1));
      res_val <= last_d;                 // one pulse per codeword
      if (last_d) begin
        res_word <= asm_word;
        res_mag  <= dat;                 // list settled after last insert
        res_pos  <= idx;
      end
    end
  end

endmodule

/* golay24_lrp_top.sv */
// golay24 least reliable position front end
// llr magnitude extraction, ascending sort list and result capture
// for a soft decision golay(24,12) decoder

`timescale 1ns/1ps

`include "golay24_settings.svh"

module golay24_lrp_top (
  input  logic                      iclk,
  input  logic                      rst_n,
  input  logic                      clkena,   // global stall
  input  logic                      sop,
  input  logic                      val,
  input  golay24_soft_pkg::llr_t    llr,
  output logic                      res_val,
  output golay24_code_pkg::word_t   res_word,
  output golay24_soft_pkg::mag_t    res_mag [`GOLAY24_LRP_NUM],
  output golay24_code_pkg::pos_t    res_pos [`GOLAY24_LRP_NUM]
);

  //------------------------------------------------------------
  // stage links
  //------------------------------------------------------------
  logic                    s1_load;
  logic                    s1_val;
  logic                    s1_hard;
  golay24_soft_pkg::mag_t  s1_mag;
  golay24_code_pkg::pos_t  s1_pos;
  golay24_soft_pkg::mag_t  list_dat [`GOLAY24_LRP_NUM];
  golay24_code_pkg::pos_t  list_idx [`GOLAY24_LRP_NUM];

  golay24_llr_mag u_llr_mag (
    .iclk (iclk), .rst_n (rst_n), .clkena (clkena),
    .sop (sop), .val (val), .llr (llr),
    .load (s1_load), .val_out (s1_val), .hard (s1_hard),
    .mag (s1_mag), .pos (s1_pos)
  );

  golay24_dec_sort_list #(
    .pIDX_NUM (`GOLAY24_LRP_NUM)
  ) u_sort_list (
    .iclk (iclk), .rst_n (rst_n), .clkena (clkena),
    .load (s1_load), .val (s1_val), .dat (s1_mag), .idx (s1_pos),
    .odat (list_dat), .oidx (list_idx)
  );

  golay24_lrp_out u_lrp_out (
    .iclk (iclk), .rst_n (rst_n), .clkena (clkena),
    .val (s1_val), .hard (s1_hard), .pos (s1_pos),
    .dat (list_dat), .idx (list_idx),
    .res_val (res_val), .res_word (res_word),
    .res_mag (res_mag), .res_pos (res_pos)
  );

endmodule

/* golay24_lrp_checker.sv */
// golay24 front end checker
// collects the accepted llrs of each codeword, builds the expected
// hard word and least reliable list, compares every result pulse

`timescale 1ns/1ps

`include "golay24_settings.svh"

module golay24_lrp_checker (
  input  logic                      iclk,
  input  logic                      rst_n,
  input  logic                      clkena,
  input  logic                      sop,
  input  logic                      val,
  input  golay24_soft_pkg::llr_t    llr,
  input  logic                      res_val,
  input  golay24_code_pkg::word_t   res_word,
  input  golay24_soft_pkg::mag_t    res_mag [`GOLAY24_LRP_NUM],
  input  golay24_code_pkg::pos_t    res_pos [`GOLAY24_LRP_NUM],
  output int                        n_checked,
  output int                        n_errors,
  output int                        n_pending   // codewords still waiting
);

  localparam int NUM = `GOLAY24_LRP_NUM;
  localparam int MW  = `GOLAY24_MAG_W;
  localparam int PW  = `GOLAY24_POS_W;

  typedef logic [NUM*MW-1:0] mag_list_t;  // entry k at bits k*MW
  typedef logic [NUM*PW-1:0] pos_list_t;

  golay24_soft_pkg::llr_t   cw [`GOLAY24_N];  // symbols of current codeword
  int                       n_sym;
  int                       bad;
  golay24_code_pkg::word_t  w_exp;
  mag_list_t                m_exp;
  pos_list_t                p_exp;
  golay24_code_pkg::word_t  word_q [$];
  mag_list_t                mag_q [$];
  pos_list_t                pos_q [$];

  //------------------------------------------------------------
  // reference model
  //------------------------------------------------------------
  function automatic void expected_result(input golay24_soft_pkg::llr_t l [`GOLAY24_N],
                                          output golay24_code_pkg::word_t w,
                                          output mag_list_t ml, output pos_list_t pl);
    int m [`GOLAY24_N];
    bit used [`GOLAY24_N];
    int best;
    for (int i = 0; i < `GOLAY24_N; i++) begin
      w[i]    = (l[i] < 0);                              // negative llr is bit 1
      m[i]    = (l[i] < 0) ? -int'(l[i]) : int'(l[i]);
      m[i]    = (m[i] > (1 << MW) - 1) ? (1 << MW) - 1 : m[i];  // clip most negative
      used[i] = 1'b0;
    end
    for (int k = 0; k < NUM; k++) begin
      best = -1;
      for (int i = 0; i < `GOLAY24_N; i++) begin
        if (!used[i] && (best < 0 || m[i] < m[best])) best = i;  // strict, lowest index wins ties
      end
      used[best]        = 1'b1;
      ml[k*MW +: MW]    = golay24_soft_pkg::mag_t'(m[best]);
      pl[k*PW +: PW]    = golay24_code_pkg::pos_t'(best);
    end
  endfunction

  //------------------------------------------------------------
  // compare first, then collect, on each enabled edge
  //------------------------------------------------------------
  always @(posedge iclk) begin
    if (!rst_n) begin
      n_sym     = 0;
      n_checked = 0;
      n_errors  = 0;
    end else if (clkena) begin
      if (res_val) begin
        if (word_q.size() == 0) begin
          $display("result pulse arrived with no codeword pending");
          n_errors++;
        end else begin
          w_exp = word_q.pop_front();
          m_exp = mag_q.pop_front();
          p_exp = pos_q.pop_front();
          bad   = 0;
          if (res_word !== w_exp) begin
            $display("Mismatch res_word: got %h expected %h", res_word, w_exp);
            bad++;
          end
          for (int k = 0; k < NUM; k++) begin
            if (res_mag[k] !== m_exp[k*MW +: MW]) begin
              $display("Mismatch res_mag[%0d]: got %h expected %h", k, res_mag[k],
                       m_exp[k*MW +: MW]);
              bad++;
            end
            if (res_pos[k] !== p_exp[k*PW +: PW]) begin
              $display("Mismatch res_pos[%0d]: got %h expected %h", k, res_pos[k],
                       p_exp[k*PW +: PW]);
              bad++;
            end
          end
          n_errors += bad;
          $display("codeword %0d: %s", n_checked, (bad == 0) ? "pass" : "fail");
          n_checked++;
        end
      end
      if (val) begin
        if (sop) n_sym = 0;                    // realign on symbol 0
        cw[n_sym] = llr;
        n_sym++;
        if (n_sym == `GOLAY24_N) begin
          expected_result(cw, w_exp, m_exp, p_exp);
          word_q.push_back(w_exp);
          mag_q.push_back(m_exp);
          pos_q.push_back(p_exp);
          n_sym = 0;
        end
      end
    end
    n_pending = word_q.size();
  end

endmodule

/* golay24_lrp_tb.sv */
// golay24 front end testbench
// random, tie, saturation and stalled codewords driven into the DUT,
// results checked by golay24_lrp_checker

`timescale 1ns/1ps

`include "golay24_settings.svh"

module golay24_lrp_tb;

  localparam int CLK_PERIOD = 100;
  localparam int N_CW       = 16;   // 6 random, 1 tie, 1 saturation, 8 stalled
  localparam int WORST_GAP  = 8;    // symbol forced in after this many tries
  localparam int LIMIT_CYC  = N_CW * `GOLAY24_N * WORST_GAP + 100;

  logic                     iclk;
  logic                     rst_n;
  logic                     clkena;
  logic                     sop;
  logic                     val;
  golay24_soft_pkg::llr_t   llr;
  logic                     res_val;
  golay24_code_pkg::word_t  res_word;
  golay24_soft_pkg::mag_t   res_mag [`GOLAY24_LRP_NUM];
  golay24_code_pkg::pos_t   res_pos [`GOLAY24_LRP_NUM];
  int                       n_checked;
  int                       n_errors;
  int                       n_pending;
  logic [15:0]              lfsr_state = 16'd8;   // seed

  golay24_lrp_top DUT (
    .iclk (iclk), .rst_n (rst_n), .clkena (clkena), .sop (sop), .val (val), .llr (llr),
    .res_val (res_val), .res_word (res_word), .res_mag (res_mag), .res_pos (res_pos)
  );

  golay24_lrp_checker u_checker (
    .iclk (iclk), .rst_n (rst_n), .clkena (clkena), .sop (sop), .val (val), .llr (llr),
    .res_val (res_val), .res_word (res_word), .res_mag (res_mag), .res_pos (res_pos),
    .n_checked (n_checked), .n_errors (n_errors), .n_pending (n_pending)
  );

  initial begin
    iclk = 1'b0;
    forever #(CLK_PERIOD / 2) iclk = ~iclk;
  end

  //------------------------------------------------------------
  // stimulus helpers
  //------------------------------------------------------------
  function automatic logic [7:0] take_bits(input int n);  // galois lfsr stepped once per bit
    logic [7:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r          = {r[6:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
    end
    return r;
  endfunction

  task automatic send_symbol(input golay24_soft_pkg::llr_t v, input bit first, input bit stall);
    bit done;
    bit ce;
    bit gap;
    int tries;
    done  = 1'b0;
    tries = 0;
    while (!done) begin
      @(negedge iclk);
      tries++;
      ce  = 1'b1;
      gap = 1'b0;
      if (stall && tries < WORST_GAP) begin
        ce  = (take_bits(2) != 8'd0);          // stall one cycle in four
        gap = (take_bits(2) == 8'd0);          // idle symbol slot one in four
      end
      clkena = ce;
      val    = !gap;
      sop    = first && !gap;
      llr    = v;
      done   = ce && !gap;
    end
  endtask

  task automatic send_codeword(input int kind, input bit stall);  // 0 random, 1 tie, 2 sat
    golay24_soft_pkg::llr_t v;
    for (int i = 0; i < `GOLAY24_N; i++) begin
      case (kind)
        1:       v = take_bits(1) ? -8'sd20 : 8'sd20;          // equal magnitudes
        2:       v = (i == 5)     ? -8'sd3 :                   // three small entries
                     (i == 11)    ? 8'sd1 :
                     (i == 17)    ? -8'sd2 :
                     (i % 2 == 0) ? 8'sh80 : 8'sh7f;           // most negative and max
        default: v = take_bits(8);
      endcase
      send_symbol(v, (i == 0), stall);
    end
  endtask

  //------------------------------------------------------------
  // test sequence
  //------------------------------------------------------------
  initial begin
    rst_n  = 1'b0;
    clkena = 1'b0;
    sop    = 1'b0;
    val    = 1'b0;
    llr    = '0;
    repeat (5) @(posedge iclk);
    @(negedge iclk);
    rst_n  = 1'b1;
    clkena = 1'b1;
    for (int c = 0; c < 6; c++) send_codeword(0, 1'b0);   // back to back
    send_codeword(1, 1'b0);
    send_codeword(2, 1'b0);
    for (int c = 0; c < 8; c++) send_codeword(0, 1'b1);   // stalls and gaps
    @(negedge iclk);
    clkena = 1'b1;
    val    = 1'b0;
    sop    = 1'b0;
    while (n_checked < N_CW) @(posedge iclk);
    repeat (5) @(posedge iclk);                           // catch extra pulses
    $display("results %0d of %0d, errors %0d, pending %0d", n_checked, N_CW, n_errors, n_pending);
    if (n_errors == 0 && n_pending == 0 && n_checked == N_CW) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(LIMIT_CYC * CLK_PERIOD);
    $display("timeout, only %0d of %0d results arrived", n_checked, N_CW);
    $display("Test failed");
    $finish;
  end

endmodule

/* all.f */
+incdir+.
golay24_soft_pkg.sv
golay24_code_pkg.sv
golay24_llr_mag.sv
golay24_dec_sort_list_cell.sv
golay24_dec_sort_list.sv
golay24_lrp_out.sv
golay24_lrp_top.sv
golay24_lrp_checker.sv
golay24_lrp_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := golay24_lrp_tb
FILELIST  := all.f
BUILD     := obj_dir
LOG       := sim.log
PASS_MSG  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
